/* common/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

// only the low index bits select an entry
`define NUM_REGS 16

// first fetch address after reset
`define RESET_PC 32'h3000_0000

// identity CSR contents
`define MVENDORID_VAL 32'h0000_0b41
`define MARCHID_VAL 32'h0000_7c0e

`endif

/* common/isa_pkg.sv */
`default_nettype none
`include "core_defines.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_ADDI,
    OP_LUI,
    OP_JALR,
    OP_LW,
    OP_LBU,
    OP_SW,
    OP_SB,
    OP_CSRRW,
    OP_CSRRS,
    OP_ILLEGAL
  } op_kind_t;

  // supported counter and identity addresses
  localparam csr_addr_t CSR_CYCLE     = 12'hB00;
  localparam csr_addr_t CSR_CYCLEH    = 12'hB80;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
`default_nettype none
`include "core_defines.svh"

package bus_pkg;

  typedef logic [3:0] byte_mask_t;

  // same encoding as the memory side expects
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_WORD = 2'd2
  } mem_size_t;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic             wen;
    logic [`XLEN-1:0] wdata;
    byte_mask_t       mask;
    mem_size_t        size;
  } data_req_t;

endpackage

`default_nettype wire

/* hdl/mem_requester.sv */
`default_nettype none

module mem_requester
  import isa_pkg::*;
  import bus_pkg::*;
#(
  parameter type req_t = data_req_t
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  req_t  req_in,
  input  logic  resp_valid,
  input  word_t rdata,
  output logic  req_valid,
  output req_t  req,
  output logic  done,
  output word_t rdata_q
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      req_valid <= 1'b0;
      done      <= 1'b0;
      req       <= '0;
    end else begin
      // both strobes last a single cycle
      req_valid <= 1'b0;
      done      <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state     <= ST_WAIT;
            req_valid <= 1'b1;
            req       <= req_in;
          end
        end
        ST_WAIT: begin
          if (resp_valid) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // read word, kept until the next response
  always_ff @(posedge clk) begin
    if (state == ST_WAIT && resp_valid) begin
      rdata_q <= rdata;
    end
  end

endmodule

`default_nettype wire

/* decode/inst_decoder.sv */
`default_nettype none

module inst_decoder
  import isa_pkg::*;
(
  input  word_t     inst,
  output op_kind_t  op,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd,
  output word_t     imm,
  output csr_addr_t csr_addr
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign rd       = inst[11:7];
  assign csr_addr = inst[31:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};

  // opcode and funct fields to operation kind
  always_comb begin
    op = OP_ILLEGAL;
    case (opcode)
      OPC_OP:     if (funct3 == 3'b000 && funct7 == 7'b0) op = OP_ADD;
      OPC_OP_IMM: if (funct3 == 3'b000) op = OP_ADDI;
      OPC_LUI:    op = OP_LUI;
      OPC_JALR:   if (funct3 == 3'b000) op = OP_JALR;
      OPC_LOAD: begin
        if (funct3 == 3'b010) op = OP_LW;
        else if (funct3 == 3'b100) op = OP_LBU;
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) op = OP_SW;
        else if (funct3 == 3'b000) op = OP_SB;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b001) op = OP_CSRRW;
        else if (funct3 == 3'b010) op = OP_CSRRS;
      end
      default: op = OP_ILLEGAL;
    endcase
  end

  // immediate format per kind
  always_comb begin
    case (op)
      OP_ADDI, OP_JALR, OP_LW, OP_LBU: imm = imm_i;
      OP_SW, OP_SB:                    imm = imm_s;
      OP_LUI:                          imm = imm_u;
      default:                         imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none
`include "core_defines.svh"

module reg_file
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  reg_idx_t waddr,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  word_t    wdata,
  output word_t    rdata1,
  output word_t    rdata2
);

  localparam int IDX_W = $clog2(`NUM_REGS);

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr[IDX_W-1:0] != '0) begin
      regs[waddr[IDX_W-1:0]] <= wdata;
    end
  end

  // entry zero is hardwired
  assign rdata1 = (raddr1[IDX_W-1:0] == '0) ? '0 : regs[raddr1[IDX_W-1:0]];
  assign rdata2 = (raddr2[IDX_W-1:0] == '0) ? '0 : regs[raddr2[IDX_W-1:0]];

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`default_nettype none
`include "core_defines.svh"

module csr_unit
  import isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      commit,
  input  op_kind_t  op,
  input  csr_addr_t addr,
  input  word_t     wdata,
  output word_t     rdata
);

  logic [63:0] cycle_q;
  logic        csr_wen;
  word_t       new_val;

  always_comb begin
    case (addr)
      CSR_CYCLE:     rdata = cycle_q[31:0];
      CSR_CYCLEH:    rdata = cycle_q[63:32];
      CSR_MVENDORID: rdata = word_t'(`MVENDORID_VAL);
      CSR_MARCHID:   rdata = word_t'(`MARCHID_VAL);
      default:       rdata = '0;
    endcase
  end

  // csrrs with a zero mask does not write
  assign csr_wen = commit && (op == OP_CSRRW || (op == OP_CSRRS && wdata != '0));
  assign new_val = (op == OP_CSRRW) ? wdata : (rdata | wdata);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 64'd1;
      // identity registers fall through, read only
      if (csr_wen) begin
        case (addr)
          CSR_CYCLE:  cycle_q[31:0] <= new_val;
          CSR_CYCLEH: cycle_q[63:32] <= new_val;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`default_nettype none

module exec_unit
  import isa_pkg::*;
(
  input  op_kind_t op,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    imm,
  input  word_t    csr_rdata,
  output word_t    addr_sum,
  output word_t    result,
  output word_t    next_pc
);

  word_t operand_b;
  word_t pc_plus4;

  // one adder for add, addi and address generation
  assign operand_b = (op == OP_ADD) ? rs2_data : imm;
  assign addr_sum  = rs1_data + operand_b;
  assign pc_plus4  = pc + word_t'(4);

  // jalr target drops bit 0
  assign next_pc = (op == OP_JALR) ? (addr_sum & ~word_t'(1)) : pc_plus4;

  always_comb begin
    case (op)
      OP_JALR:            result = pc_plus4;
      OP_CSRRW, OP_CSRRS: result = csr_rdata;
      OP_LUI:             result = imm;
      default:            result = addr_sum;
    endcase
  end

endmodule

`default_nettype wire

/* lsu/load_store_unit.sv */
`default_nettype none

module load_store_unit
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  op_kind_t   op,
  input  word_t      addr,
  input  word_t      store_data,
  input  logic       resp_valid,
  input  word_t      rdata,
  output logic       req_valid,
  output logic       wen,
  output word_t      req_addr,
  output word_t      wdata,
  output byte_mask_t wmask,
  output mem_size_t  size,
  output logic       done,
  output word_t      load_data
);

  data_req_t  req_in;
  data_req_t  req;
  logic [1:0] lane;
  logic       is_store;
  logic       is_byte;
  byte_mask_t base_mask;
  word_t      rdata_q;
  word_t      shifted;

  assign lane      = addr[1:0];
  assign is_store  = (op == OP_SW) || (op == OP_SB);
  assign is_byte   = (op == OP_SB) || (op == OP_LBU);
  assign base_mask = is_byte ? 4'b0001 : 4'b1111;

  // ========================================
  // request formation, data moved into its byte lane
  always_comb begin
    req_in.addr  = addr;
    req_in.wen   = is_store;
    req_in.wdata = store_data << {lane, 3'b000};
    req_in.mask  = base_mask << lane;
    req_in.size  = is_byte ? SIZE_BYTE : SIZE_WORD;
  end

  mem_requester #(
    .req_t(data_req_t)
  ) data_req_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .req_in    (req_in),
    .resp_valid(resp_valid),
    .rdata     (rdata),
    .req_valid (req_valid),
    .req       (req),
    .done      (done),
    .rdata_q   (rdata_q)
  );

  assign req_addr = req.addr;
  assign wen      = req.wen;
  assign wdata    = req.wdata;
  assign wmask    = req.mask;
  assign size     = req.size;

  // ========================================
  // load extraction from the full aligned word
  assign shifted   = rdata_q >> {req.addr[1:0], 3'b000};
  assign load_data = (op == OP_LBU) ? word_t'(shifted[7:0]) : shifted;

endmodule

`default_nettype wire

/* hdl/core_sequencer.sv */
`default_nettype none
`include "core_defines.svh"

module core_sequencer
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fetch_done,
  input  word_t    fetch_word,
  input  op_kind_t op,
  input  word_t    next_pc,
  input  word_t    result,
  input  logic     lsu_done,
  input  word_t    load_data,
  output logic     fetch_start,
  output word_t    pc,
  output word_t    inst,
  output logic     lsu_start,
  output logic     commit,
  output logic     rd_we,
  output word_t    rd_wdata
);

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_FETCH_WAIT,
    ST_EXEC,
    ST_MEM,
    ST_COMMIT
  } state_t;

  state_t state;
  logic   is_mem;
  logic   is_load;

  assign is_load = (op == OP_LW) || (op == OP_LBU);
  assign is_mem  = is_load || (op == OP_SW) || (op == OP_SB);

  assign fetch_start = (state == ST_FETCH);
  assign lsu_start   = (state == ST_EXEC) && is_mem;
  assign commit      = (state == ST_COMMIT);

  // stores and illegal words leave the register file alone
  assign rd_we    = commit && op != OP_SW && op != OP_SB && op != OP_ILLEGAL;
  assign rd_wdata = is_load ? load_data : result;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= `RESET_PC;
    end else begin
      case (state)
        ST_FETCH:      state <= ST_FETCH_WAIT;
        ST_FETCH_WAIT: if (fetch_done) state <= ST_EXEC;
        ST_EXEC:       state <= is_mem ? ST_MEM : ST_COMMIT;
        ST_MEM:        if (lsu_done) state <= ST_COMMIT;
        ST_COMMIT: begin
          state <= ST_FETCH;
          pc    <= next_pc;
        end
        default:       state <= ST_FETCH;
      endcase
    end
  end

  // instruction held from fetch until commit
  always_ff @(posedge clk) begin
    if (state == ST_FETCH_WAIT && fetch_done) begin
      inst <= fetch_word;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic       ifu_req_valid,
  output word_t      ifu_addr,
  input  logic       ifu_resp_valid,
  input  word_t      ifu_rdata,
  output logic       lsu_req_valid,
  output word_t      lsu_addr,
  output logic       lsu_wen,
  output word_t      lsu_wdata,
  output byte_mask_t lsu_wmask,
  output mem_size_t  lsu_size,
  input  logic       lsu_resp_valid,
  input  word_t      lsu_rdata
);

  logic      fetch_start, fetch_done, lsu_start, lsu_done, commit, rd_we;
  word_t     pc, inst, fetch_word, next_pc, result, load_data, rd_wdata;
  word_t     imm, rs1_data, rs2_data, csr_rdata, addr_sum;
  op_kind_t  op;
  reg_idx_t  rs1, rs2, rd;
  csr_addr_t csr_addr;

  // instruction fetch port
  mem_requester #(.req_t(word_t)) fetch_req_i (
    .clk(clk), .rst(rst), .start(fetch_start), .req_in(pc),
    .resp_valid(ifu_resp_valid), .rdata(ifu_rdata), .req_valid(ifu_req_valid),
    .req(ifu_addr), .done(fetch_done), .rdata_q(fetch_word)
  );

  inst_decoder decoder_i (
    .inst(inst), .op(op), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .csr_addr(csr_addr)
  );

  reg_file reg_file_i (
    .clk(clk), .rst(rst), .we(rd_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
    .wdata(rd_wdata), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  // csr write operand is rs1
  csr_unit csr_i (
    .clk(clk), .rst(rst), .commit(commit), .op(op), .addr(csr_addr),
    .wdata(rs1_data), .rdata(csr_rdata)
  );

  exec_unit exec_i (
    .op(op), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .csr_rdata(csr_rdata), .addr_sum(addr_sum), .result(result), .next_pc(next_pc)
  );

  load_store_unit lsu_i (
    .clk(clk), .rst(rst), .start(lsu_start), .op(op), .addr(addr_sum),
    .store_data(rs2_data), .resp_valid(lsu_resp_valid), .rdata(lsu_rdata),
    .req_valid(lsu_req_valid), .wen(lsu_wen), .req_addr(lsu_addr), .wdata(lsu_wdata),
    .wmask(lsu_wmask), .size(lsu_size), .done(lsu_done), .load_data(load_data)
  );

  core_sequencer seq_i (
    .clk(clk), .rst(rst), .fetch_done(fetch_done), .fetch_word(fetch_word), .op(op),
    .next_pc(next_pc), .result(result), .lsu_done(lsu_done), .load_data(load_data),
    .fetch_start(fetch_start), .pc(pc), .inst(inst), .lsu_start(lsu_start),
    .commit(commit), .rd_we(rd_we), .rd_wdata(rd_wdata)
  );

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`default_nettype none
`include "core_defines.svh"

module rv_core_tb
  import isa_pkg::*;
  import bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         IMEM_WORDS = 128;
  localparam int         DMEM_WORDS = 128;
  localparam int         WORST_CPI  = 18;
  localparam word_t      DATA_BASE  = 32'h0000_0100;
  localparam word_t      LBU_OFF    = 32'h0000_0080;
  localparam word_t      LBU_WORD   = 32'h8C4B_2A91;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic       clk;
  logic       rst;
  logic       ifu_req_valid;
  word_t      ifu_addr;
  logic       ifu_resp_valid;
  word_t      ifu_rdata;
  logic       lsu_req_valid;
  word_t      lsu_addr;
  logic       lsu_wen;
  word_t      lsu_wdata;
  byte_mask_t lsu_wmask;
  mem_size_t  lsu_size;
  logic       lsu_resp_valid;
  word_t      lsu_rdata;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];

  // program words with their expected next fetch, and the expected stores
  word_t      prog_q[$];
  word_t      next_q[$];
  word_t      st_addr_q[$];
  word_t      st_data_q[$];
  byte_mask_t st_mask_q[$];
  mem_size_t  st_size_q[$];

  integer seed;
  int     errors;
  int     store_idx;
  int     cycles = 0;
  int     cycle_limit;
  word_t  exp_fetch;
  logic   i_busy;
  logic   d_busy;
  int     i_cnt;
  int     d_cnt;
  word_t  i_addr_q;
  word_t  d_addr_q;

  rv_core rv_core_i (
    .clk(clk), .rst(rst),
    .ifu_req_valid(ifu_req_valid), .ifu_addr(ifu_addr),
    .ifu_resp_valid(ifu_resp_valid), .ifu_rdata(ifu_rdata),
    .lsu_req_valid(lsu_req_valid), .lsu_addr(lsu_addr), .lsu_wen(lsu_wen),
    .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask), .lsu_size(lsu_size),
    .lsu_resp_valid(lsu_resp_valid), .lsu_rdata(lsu_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // ========================================
  // instruction encoding
  function automatic word_t i_format(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_format(logic [11:0] imm, reg_idx_t rs2, logic [2:0] f3);
    // base register is always x1
    return {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t u_format(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t add_format(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t csr_format(logic [2:0] f3, csr_addr_t csr, reg_idx_t rs1,
                                       reg_idx_t rd);
    return {csr, rs1, f3, rd, 7'b1110011};
  endfunction

  function automatic word_t pc_of(int idx);
    return `RESET_PC + word_t'(idx * 4);
  endfunction

  function automatic word_t fill_word(word_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  task automatic emit(input word_t w);
    next_q.push_back(pc_of(prog_q.size()) + 4);
    prog_q.push_back(w);
  endtask

  task automatic emit_jump(input word_t w, input word_t target);
    next_q.push_back(target);
    prog_q.push_back(w);
  endtask

  task automatic expect_store(input word_t addr, input word_t data, input byte_mask_t mask,
                              input mem_size_t size);
    st_addr_q.push_back(addr);
    st_data_q.push_back(data);
    st_mask_q.push_back(mask);
    st_size_q.push_back(size);
  endtask

  task automatic store_word(input reg_idx_t rs2, input logic [11:0] off, input word_t data);
    emit(s_format(off, rs2, 3'b010));
    expect_store(DATA_BASE + word_t'(off), data, 4'hF, SIZE_WORD);
  endtask

  task automatic store_byte(input reg_idx_t rs2, input logic [11:0] off, input logic [7:0] b);
    int lane;
    lane = int'(off[1:0]);
    emit(s_format(off, rs2, 3'b000));
    expect_store(DATA_BASE + word_t'(off), word_t'(b) << (8 * lane),
                 byte_mask_t'(1 << lane), SIZE_BYTE);
  endtask

  // ========================================
  // program and expected stores
  task automatic build_program();
    int jalr_idx;
    emit(i_format(12'h100, 5'd0, 3'b000, 5'd1, OPC_IMM));
    emit(i_format(12'd123, 5'd0, 3'b000, 5'd2, OPC_IMM));
    emit(u_format(20'h12345, 5'd3));
    emit(add_format(5'd4, 5'd2, 5'd3));
    emit(i_format(12'd77, 5'd0, 3'b000, 5'd0, OPC_IMM));
    store_word(5'd2, 12'h000, 32'd123);
    store_word(5'd3, 12'h004, 32'h1234_5000);
    store_word(5'd4, 12'h008, 32'h1234_5000 + 32'd123);
    store_word(5'd0, 12'h00C, 32'd0);
    // one byte into each lane
    emit(i_format(12'h0A5, 5'd0, 3'b000, 5'd5, OPC_IMM));
    for (int k = 0; k < 4; k++) store_byte(5'd5, 12'h010 + 12'(k), 8'hA5);
    for (int k = 0; k < 4; k++) begin
      emit(i_format(LBU_OFF[11:0] + 12'(k), 5'd1, 3'b100, 5'd8, OPC_LOAD));
      store_word(5'd8, 12'h020 + 12'(4 * k), {24'b0, LBU_WORD[8*k +: 8]});
    end
    emit(i_format(12'h008, 5'd1, 3'b010, 5'd8, OPC_LOAD));
    store_word(5'd8, 12'h030, 32'h1234_5000 + 32'd123);
    emit(i_format(12'h084, 5'd1, 3'b010, 5'd8, OPC_LOAD));
    store_word(5'd8, 12'h034, fill_word(DATA_BASE + 32'h84));
    // jalr with odd offset skips two words that would set x9
    emit(u_format(20'(`RESET_PC >> 12), 5'd6));
    jalr_idx = prog_q.size();
    emit_jump(i_format(12'((jalr_idx + 3) * 4 + 1), 5'd6, 3'b000, 5'd7, OPC_JALR),
              pc_of(jalr_idx + 3));
    emit(i_format(12'h7FF, 5'd0, 3'b000, 5'd9, OPC_IMM));
    emit(i_format(12'h7FF, 5'd0, 3'b000, 5'd9, OPC_IMM));
    store_word(5'd7, 12'h038, pc_of(jalr_idx) + 4);
    store_word(5'd9, 12'h03C, 32'd0);
    // identity reads, then the counter high half and the read-only vendor
    emit(csr_format(3'b010, CSR_MVENDORID, 5'd0, 5'd10));
    store_word(5'd10, 12'h040, `MVENDORID_VAL);
    emit(csr_format(3'b010, CSR_MARCHID, 5'd0, 5'd10));
    store_word(5'd10, 12'h044, `MARCHID_VAL);
    emit(i_format(12'd5, 5'd0, 3'b000, 5'd11, OPC_IMM));
    emit(csr_format(3'b001, CSR_CYCLEH, 5'd11, 5'd0));
    emit(csr_format(3'b010, CSR_CYCLEH, 5'd0, 5'd12));
    store_word(5'd12, 12'h048, 32'd5);
    emit(csr_format(3'b010, CSR_CYCLEH, 5'd0, 5'd0));
    emit(csr_format(3'b010, CSR_CYCLEH, 5'd0, 5'd12));
    store_word(5'd12, 12'h04C, 32'd5);
    emit(i_format(12'h030, 5'd0, 3'b000, 5'd13, OPC_IMM));
    emit(csr_format(3'b010, CSR_CYCLEH, 5'd13, 5'd0));
    emit(csr_format(3'b010, CSR_CYCLEH, 5'd0, 5'd12));
    store_word(5'd12, 12'h050, 32'd5 | 32'h30);
    emit(csr_format(3'b001, CSR_MVENDORID, 5'd11, 5'd0));
    emit(csr_format(3'b010, CSR_MVENDORID, 5'd0, 5'd10));
    store_word(5'd10, 12'h054, `MVENDORID_VAL);
  endtask

  task automatic load_memories();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog_q.size()) ? prog_q[i] : '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(word_t'(i * 4));
    end
    dmem[(DATA_BASE + LBU_OFF) >> 2] = LBU_WORD;
  endtask

  function automatic word_t next_fetch(word_t a);
    word_t off;
    off = a - `RESET_PC;
    if (off < word_t'(prog_q.size() * 4)) return next_q[off >> 2];
    return a + 4;
  endfunction

  function automatic word_t imem_read(word_t a);
    word_t off;
    off = a - `RESET_PC;
    if (off < IMEM_WORDS * 4) return imem[off[8:2]];
    return '0;
  endfunction

  function automatic word_t dmem_read(word_t a);
    if (a < DMEM_WORDS * 4) return dmem[a[8:2]];
    return fill_word({a[31:2], 2'b00});
  endfunction

  task automatic write_dmem(input word_t a, input word_t data, input byte_mask_t mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b] && a < DMEM_WORDS * 4) dmem[a[8:2]][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  // ========================================
  // checks
  task automatic check_store(input word_t addr, input word_t data, input byte_mask_t mask,
                             input mem_size_t size, input word_t exp_addr,
                             input word_t exp_data, input byte_mask_t exp_mask,
                             input mem_size_t exp_size);
    if (addr !== exp_addr || data !== exp_data || mask !== exp_mask || size !== exp_size) begin
      $display("mismatch at %0t: store got %h/%h/%b/%0d, expected %h/%h/%b/%0d", $time,
               addr, data, mask, size, exp_addr, exp_data, exp_mask, exp_size);
      errors++;
    end
  endtask

  task automatic check_fetch(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: fetch address %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  // instruction memory model with a delay of 1 to 4 cycles
  always @(posedge clk) begin
    if (rst) begin
      ifu_resp_valid <= 1'b0;
      i_busy         <= 1'b0;
    end else begin
      ifu_resp_valid <= 1'b0;
      if (ifu_req_valid) begin
        if (i_busy) begin
          $display("error at %0t: fetch request while one is outstanding", $time);
          errors++;
        end
        check_fetch(ifu_addr, exp_fetch);
        exp_fetch <= next_fetch(ifu_addr);
        i_addr_q  <= ifu_addr;
        i_cnt     <= 1 + ($random(seed) & 3);
        i_busy    <= 1'b1;
      end else if (i_busy) begin
        if (i_cnt == 1) begin
          ifu_resp_valid <= 1'b1;
          ifu_rdata      <= imem_read(i_addr_q);
          i_busy         <= 1'b0;
        end else begin
          i_cnt <= i_cnt - 1;
        end
      end
    end
  end

  // data memory model checking each write against the store table
  always @(posedge clk) begin
    if (rst) begin
      lsu_resp_valid <= 1'b0;
      d_busy         <= 1'b0;
    end else begin
      lsu_resp_valid <= 1'b0;
      if (lsu_req_valid) begin
        if (d_busy) begin
          $display("error at %0t: data request while one is outstanding", $time);
          errors++;
        end
        if (lsu_wen && store_idx < st_addr_q.size()) begin
          check_store(lsu_addr, lsu_wdata, lsu_wmask, lsu_size, st_addr_q[store_idx],
                      st_data_q[store_idx], st_mask_q[store_idx], st_size_q[store_idx]);
        end else if (lsu_wen) begin
          $display("error at %0t: unexpected store to %h after the last one", $time, lsu_addr);
          errors++;
        end
        if (lsu_wen) begin
          write_dmem(lsu_addr, lsu_wdata, lsu_wmask);
          store_idx++;
        end
        d_addr_q <= lsu_addr;
        d_cnt    <= 1 + ($random(seed) & 3);
        d_busy   <= 1'b1;
      end else if (d_busy) begin
        if (d_cnt == 1) begin
          lsu_resp_valid <= 1'b1;
          lsu_rdata      <= dmem_read(d_addr_q);
          d_busy         <= 1'b0;
        end else begin
          d_cnt <= d_cnt - 1;
        end
      end
    end
  end

  initial begin
    rst            = 1'b1;
    ifu_resp_valid = 1'b0;
    ifu_rdata      = '0;
    lsu_resp_valid = 1'b0;
    lsu_rdata      = '0;
    seed           = 31282;
    errors         = 0;
    store_idx      = 0;
    exp_fetch      = `RESET_PC;
    build_program();
    load_memories();
    cycle_limit = prog_q.size() * WORST_CPI * 2 + 50;
    repeat (2) @(posedge clk);
    if (ifu_req_valid !== 1'b0 || lsu_req_valid !== 1'b0 || lsu_wen !== 1'b0) begin
      $display("error: a request valid or the write enable is not low during reset");
      errors++;
    end
    rst <= 1'b0;
    while (store_idx < st_addr_q.size() && cycles < cycle_limit) @(posedge clk);
    if (store_idx < st_addr_q.size()) begin
      $display("error: timeout after %0d cycles with %0d stores seen", cycles, store_idx);
      errors++;
    end else begin
      // catch stray stores after the last one
      repeat (20) @(posedge clk);
    end
    $display("summary: %0d errors, %0d of %0d stores seen", errors, store_idx,
             st_addr_q.size());
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/isa_pkg.sv
common/bus_pkg.sv
hdl/mem_requester.sv
decode/inst_decoder.sv
hdl/reg_file.sv
hdl/csr_unit.sv
hdl/exec_unit.sv
lsu/load_store_unit.sv
hdl/core_sequencer.sv
hdl/rv_core.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - common

sources:
  - common/isa_pkg.sv
  - common/bus_pkg.sv
  - hdl/mem_requester.sv
  - decode/inst_decoder.sv
  - hdl/reg_file.sv
  - hdl/csr_unit.sv
  - hdl/exec_unit.sv
  - lsu/load_store_unit.sv
  - hdl/core_sequencer.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - bench/rv_core_tb.sv
